// ==== common/FpuCvtPkg.sv ====
// Shared types for the double to single conversion path
// Operand widths, buffer sizing and the pair packer states

package FpuCvtPkg;

	// ********************
	// floating point operand types
	// ********************

	typedef logic [63:0] fpDouble_t;	// ieee double, sign/exp11/mant52
	typedef logic [31:0] fpSingle_t;	// ieee single, sign/exp8/mant23

	// paired single word
	// second single sits in bits 63:32, first single in bits 31:0
	typedef logic [63:0] fpPair_t;

	// ********************
	// buffer sizing
	// ********************

	localparam int FifoDepth = 8;		// entries in the single buffer

	typedef logic [2:0] fifoPtr_t;		// wraps naturally at FifoDepth
	typedef logic [3:0] fifoCnt_t;		// holds 0 up to FifoDepth

	// ********************
	// pair packer FSM
	// ********************

	typedef enum logic
	{
		packEmpty,						// no half latched yet
		packHalf						// lower half held, waiting for upper
	} packState_t;

endpackage

// ==== source/FpuConvD2S.sv ====
// Double to single converter, purely combinational
// Rounds on the low mantissa byte and saturates or flushes out of range values

`timescale 1ns/1ps

module FpuConvD2S
(
	input  FpuCvtPkg::fpDouble_t dVal,	// source double
	output FpuCvtPkg::fpSingle_t sVal	// converted single
);

	logic        dSign;					// sign passes straight through
	logic [10:0] dExp;					// full double exponent
	logic [8:0]  roundSum;				// low byte plus round bit, with carry
	FpuCvtPkg::fpSingle_t mapVal;		// direct mapping, rounded

	assign dSign = dVal[63];
	assign dExp  = dVal[62:52];

	// ********************
	// direct mapping and rounding
	// ********************

	always_comb
	begin
		// keep exp msb, drop exp bits 9..7, keep exp bits 6..0
		mapVal = {dSign, dVal[62], dVal[58:52], dVal[51:29]};

		roundSum = {1'b0, dVal[36:29]} + {8'b0, dVal[28]};	// bit 28 is the round bit
		if (roundSum[8])
			mapVal[7:0] = dVal[36:29];	// carry out of byte, keep truncated
		else
			mapVal[7:0] = roundSum[7:0];
	end

	// ********************
	// exponent range select
	// ********************

	always_comb
	begin
		if ((dExp[10:7] == 4'b0111) || (dExp[10:7] == 4'b1000))
		begin
			// exponent fits in 8 bits once rebiased
			sVal = mapVal;
		end
		else if (dExp == 11'h7FF)
		begin
			sVal = {dSign, 8'hFF, dVal[51:29]};		// inf / nan, payload kept
		end
		else if (dExp == 11'h000)
		begin
			sVal = {dSign, 8'h00, dVal[51:29]};		// zero / denormal, sign kept
		end
		else if (dExp[10])
		begin
			sVal = {dSign, 31'h7F800000};			// too large, signed inf
		end
		else
		begin
			sVal = 32'h00000000;					// too small, flush to +0
		end
	end

endmodule

// ==== source/FpuCvtStage.sv ====
// Producer stage for the conversion path
// Converts one double per strobe and registers the single with its strobe

`timescale 1ns/1ps

module FpuCvtStage
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 inVld,		// one double per strobe
	input  FpuCvtPkg::fpDouble_t inVal,
	output logic                 cvtVld,	// strobe, one cycle after inVld
	output FpuCvtPkg::fpSingle_t cvtVal
);

	FpuCvtPkg::fpSingle_t convVal;		// combinational converter result

	FpuConvD2S i_FpuConvD2S
	(
		.dVal (inVal),
		.sVal (convVal)
	);

	// ********************
	// output register
	// ********************

	always_ff @(posedge clock)
	begin
		if (rst)
			cvtVld <= 1'b0;
		else
			cvtVld <= inVld;

		if (inVld)
			cvtVal <= convVal;			// payload only loads on a strobe
	end

	// a strobed result must be fully known when it reaches the buffer
	cvtValKnown: assert property (@(posedge clock) disable iff (rst)
		cvtVld |-> !$isunknown(cvtVal))
		else $error("cvtVal has unknown bits while cvtVld is high");

endmodule

// ==== source/FpuCvtFifo.sv ====
// Buffer of converted singles, first word fall through
// Drops writes when full and raises a sticky overflow level

`timescale 1ns/1ps

module FpuCvtFifo
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 wrEn,		// write strobe from the stage
	input  FpuCvtPkg::fpSingle_t wrVal,
	input  logic                 pop,		// advance head on this edge
	output FpuCvtPkg::fpSingle_t headVal,	// oldest entry, valid when nonEmpty
	output logic                 nonEmpty,
	output logic                 overflow	// sticky until reset
);

	FpuCvtPkg::fpSingle_t mem [FpuCvtPkg::FifoDepth];	// entry storage

	FpuCvtPkg::fifoPtr_t wrPtr;			// next slot to fill
	FpuCvtPkg::fifoPtr_t rdPtr;			// current head slot
	FpuCvtPkg::fifoCnt_t count;			// number of live entries

	logic full;
	logic doWrite;						// write accepted this cycle
	logic doPop;						// head advances this cycle

	assign full     = (count == FpuCvtPkg::fifoCnt_t'(FpuCvtPkg::FifoDepth));
	assign nonEmpty = (count != '0);
	assign headVal  = mem[rdPtr];		// fall through, no read latency

	assign doPop   = pop && nonEmpty;
	assign doWrite = wrEn && (!full || doPop);	// full plus pop frees a slot

	// ********************
	// storage
	// ********************

	always_ff @(posedge clock)
	begin
		if (doWrite)
			mem[wrPtr] <= wrVal;
	end

	// ********************
	// pointers, count, overflow
	// ********************

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + FpuCvtPkg::fifoPtr_t'(1);	// wraps at depth
			if (doPop)
				rdPtr <= rdPtr + FpuCvtPkg::fifoPtr_t'(1);

			case ({doWrite, doPop})
				2'b10:   count <= count + FpuCvtPkg::fifoCnt_t'(1);
				2'b01:   count <= count - FpuCvtPkg::fifoCnt_t'(1);
				default: count <= count;	// both or neither
			endcase

			if (wrEn && !doWrite)
				overflow <= 1'b1;		// dropped write, latch it
		end
	end

	// the packer only pops what it can see at the head
	popNotEmpty: assert property (@(posedge clock) disable iff (rst)
		pop |-> nonEmpty)
		else $error("pop while buffer is empty");

	countInRange: assert property (@(posedge clock) disable iff (rst)
		count <= FpuCvtPkg::fifoCnt_t'(FpuCvtPkg::FifoDepth))
		else $error("buffer count exceeds depth");

endmodule

// ==== source/FpuPairPack.sv ====
// Pair packer, consumer side of the buffer
// Pops two singles while storeEn is high and emits one paired word

`timescale 1ns/1ps

module FpuPairPack
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 storeEn,	// level, low holds the packer
	input  FpuCvtPkg::fpSingle_t headVal,
	input  logic                 nonEmpty,
	output logic                 pop,		// one entry consumed per cycle
	output logic                 outVld,	// pulse with outVal
	output FpuCvtPkg::fpPair_t   outVal
);

	FpuCvtPkg::packState_t packState;	// which half comes next
	FpuCvtPkg::fpSingle_t  lowHalf;		// first single of the pair

	assign pop = storeEn && nonEmpty;

	// ********************
	// packer FSM
	// ********************

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			packState <= FpuCvtPkg::packEmpty;
			outVld    <= 1'b0;
		end
		else
		begin
			outVld <= 1'b0;				// default, pulse only
			if (pop)
			begin
				case (packState)
					FpuCvtPkg::packEmpty:
					begin
						packState <= FpuCvtPkg::packHalf;
					end
					FpuCvtPkg::packHalf:
					begin
						packState <= FpuCvtPkg::packEmpty;
						outVld    <= 1'b1;	// pair complete
					end
					default: packState <= FpuCvtPkg::packEmpty;
				endcase
			end
		end
	end

	// payload registers
	always_ff @(posedge clock)
	begin
		if (pop && (packState == FpuCvtPkg::packEmpty))
			lowHalf <= headVal;			// first pop, hold lower half
		if (pop && (packState == FpuCvtPkg::packHalf))
			outVal <= {headVal, lowHalf};	// second single goes high
	end

	// a pair takes two pops, so back to back outputs cannot happen
	outVldPulse: assert property (@(posedge clock) disable iff (rst)
		outVld |=> !outVld)
		else $error("outVld high in two consecutive cycles");

endmodule

// ==== source/FpuCvtUnit.sv ====
// Top of the double to single conversion path
// Stage feeds the buffer, the packer drains it into paired words

`timescale 1ns/1ps

module FpuCvtUnit
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 inVld,		// one double per strobe
	input  FpuCvtPkg::fpDouble_t inVal,
	input  logic                 storeEn,	// writeback enable level
	output logic                 outVld,
	output FpuCvtPkg::fpPair_t   outVal,
	output logic                 overflow	// buffer dropped a single
);

	logic                 cvtVld;		// stage to buffer strobe
	FpuCvtPkg::fpSingle_t cvtVal;
	FpuCvtPkg::fpSingle_t headVal;		// buffer head to packer
	logic                 nonEmpty;
	logic                 pop;			// packer consumes head

	FpuCvtStage i_FpuCvtStage
	(
		.clock  (clock),
		.rst    (rst),
		.inVld  (inVld),
		.inVal  (inVal),
		.cvtVld (cvtVld),
		.cvtVal (cvtVal)
	);

	FpuCvtFifo i_FpuCvtFifo
	(
		.clock    (clock),
		.rst      (rst),
		.wrEn     (cvtVld),
		.wrVal    (cvtVal),
		.pop      (pop),
		.headVal  (headVal),
		.nonEmpty (nonEmpty),
		.overflow (overflow)
	);

	FpuPairPack i_FpuPairPack
	(
		.clock    (clock),
		.rst      (rst),
		.storeEn  (storeEn),
		.headVal  (headVal),
		.nonEmpty (nonEmpty),
		.pop      (pop),
		.outVld   (outVld),
		.outVal   (outVal)
	);

endmodule

// ==== tb/FpuCvtModel.svh ====
// Reference model for the double to single conversion path
// Conversion and pairing rules as plain functions for the testbench

`ifndef FPU_CVT_MODEL_SVH
`define FPU_CVT_MODEL_SVH

// assemble a double from its three fields
function automatic FpuCvtPkg::fpDouble_t makeDouble
(
	input logic        sign,
	input logic [10:0] expField,
	input logic [51:0] mantField
);
	return {sign, expField, mantField};
endfunction

// ********************
// conversion rule
// ********************

function automatic FpuCvtPkg::fpSingle_t refConvert
(
	input FpuCvtPkg::fpDouble_t d
);
	logic                 sign;
	logic [10:0]          expField;
	logic [22:0]          mantTop;		// mantissa bits 51..29
	logic [7:0]           lowByte;
	FpuCvtPkg::fpSingle_t result;

	sign     = d[63];
	expField = d[62:52];
	mantTop  = d[51:29];

	if ((expField[10:7] == 4'b0111) || (expField[10:7] == 4'b1000))
	begin
		result  = {sign, expField[10], expField[6:0], mantTop};
		lowByte = result[7:0];
		if (d[28] && (lowByte != 8'hFF))
			result[7:0] = lowByte + 8'd1;	// round up, a full byte stays truncated
	end
	else if (expField == 11'h7FF)
		result = {sign, 8'hFF, mantTop};		// inf or nan, payload kept
	else if (expField == 11'h000)
		result = {sign, 8'h00, mantTop};		// zero or denormal
	else if (expField[10])
		result = {sign, 8'hFF, 23'h0};			// saturate to signed inf
	else
		result = 32'h0000_0000;					// flush, sign dropped

	return result;
endfunction

// pairing rule, first single in the low half
function automatic FpuCvtPkg::fpPair_t refPair
(
	input FpuCvtPkg::fpSingle_t first,
	input FpuCvtPkg::fpSingle_t second
);
	return {second, first};
endfunction

`endif

// ==== tb/FpuCvtUnitTb.sv ====
// Testbench for the double to single conversion path
// Directed tests plus random traffic, pairs checked against the reference model

`timescale 1ns/1ps

module FpuCvtUnitTb;

	localparam int RandomItems    = 200;
	localparam int TestItems      = 6 + 6 + 4 + 6 + 9 + RandomItems;
	localparam int WatchdogCycles = TestItems * 10 + 200;

	logic                 clock;
	logic                 rst;
	logic                 inVld;
	FpuCvtPkg::fpDouble_t inVal;
	logic                 storeEn;
	logic                 outVld;
	FpuCvtPkg::fpPair_t   outVal;
	logic                 overflow;

	FpuCvtPkg::fpSingle_t pendSingles [$];	// accepted singles not yet paired
	FpuCvtPkg::fpPair_t   expPairs [$];		// pairs the DUT still owes
	FpuCvtPkg::fpPair_t   wantPair;
	int                   lowRun;			// consecutive storeEn low cycles

	`include "FpuCvtModel.svh"

	FpuCvtUnit i_FpuCvtUnit
	(
		.clock    (clock),
		.rst      (rst),
		.inVld    (inVld),
		.inVal    (inVal),
		.storeEn  (storeEn),
		.outVld   (outVld),
		.outVal   (outVal),
		.overflow (overflow)
	);

	always #2 clock = ~clock;				// 4 ns period

	// ********************
	// reporting and checks
	// ********************

	task automatic stopRun();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkPair(input string name, input FpuCvtPkg::fpPair_t actVal,
		input FpuCvtPkg::fpPair_t expVal);
		if (actVal !== expVal)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, actVal, expVal);
			stopRun();
		end
	endtask

	task automatic checkLevel(input string name, input logic actVal, input logic expVal);
		if (actVal !== expVal)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, actVal, expVal);
			stopRun();
		end
	endtask

	// every output pulse must match the oldest owed pair
	always @(negedge clock)
	begin
		if (!rst && (outVld === 1'b1))
		begin
			if (expPairs.size() == 0)
			begin
				$display("outVld pulsed while no pair was outstanding");
				stopRun();
			end
			else
			begin
				wantPair = expPairs.pop_front();
				checkPair("outVal", outVal, wantPair);
			end
		end
	end

	initial
	begin
		repeat (WatchdogCycles) @(posedge clock);
		$display("watchdog expired after %0d cycles, the DUT stopped producing pairs",
			WatchdogCycles);
		stopRun();
	end

	// ********************
	// stimulus helpers
	// ********************

	task automatic expectSingle(input FpuCvtPkg::fpSingle_t s);
		pendSingles.push_back(s);
		if (pendSingles.size() == 2)
		begin
			expPairs.push_back(refPair(pendSingles[0], pendSingles[1]));
			pendSingles.delete();
		end
	endtask

	// kept is low for a value the full buffer will drop
	task automatic pushDouble(input FpuCvtPkg::fpDouble_t d, input logic kept);
		@(posedge clock);
		inVld <= 1'b1;
		inVal <= d;
		if (kept)
			expectSingle(refConvert(d));
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(posedge clock);
			inVld <= 1'b0;
		end
	endtask

	task automatic setStore(input logic en);
		@(posedge clock);
		inVld   <= 1'b0;
		storeEn <= en;
	endtask

	task automatic waitDrain(input int maxCycles);
		int waited;
		waited = 0;
		while (expPairs.size() != 0)
		begin
			if (waited >= maxCycles)
			begin
				$display("timed out waiting for %0d outstanding pairs", expPairs.size());
				stopRun();
			end
			@(posedge clock);
			waited++;
		end
	endtask

	task automatic applyReset();
		@(posedge clock);
		rst     <= 1'b1;
		inVld   <= 1'b0;
		storeEn <= 1'b0;
		repeat (16) @(posedge clock);
		rst <= 1'b0;
		pendSingles.delete();
		expPairs.delete();
	endtask

	// half in range, the rest anywhere, now and then a special
	function automatic FpuCvtPkg::fpDouble_t randomDouble(input logic inRange);
		logic [31:0]          hi;
		logic [31:0]          lo;
		FpuCvtPkg::fpDouble_t d;
		hi = $urandom;
		lo = $urandom;
		d  = {hi, lo};
		if (inRange)
			d[62:59] = hi[0] ? 4'b0111 : 4'b1000;
		else if (lo[7:4] == 4'h0)
			d[62:52] = hi[1] ? 11'h7FF : 11'h000;
		return d;
	endfunction

	// random level, never low for more than two cycles so the buffer cannot fill
	function automatic logic pickStore();
		logic en;
		if (lowRun >= 2)
			en = 1'b1;
		else
			en = (($urandom % 2) == 1);
		lowRun = en ? 0 : lowRun + 1;
		return en;
	endfunction

	// ********************
	// directed tests
	// ********************

	task automatic convertInRange();
		setStore(1'b1);
		pushDouble(makeDouble(1'b0, 11'h3FF, 52'h0000010000000), 1'b1);	// round up
		pushDouble(makeDouble(1'b0, 11'h405, 52'h55555E0000000), 1'b1);	// round bit 0
		pushDouble(makeDouble(1'b1, 11'h380, 52'h0001FF0000000), 1'b1);	// FF, no carry
		pushDouble(makeDouble(1'b0, 11'h47F, 52'h0001FD0000000), 1'b1);	// FE up to FF
		pushDouble(64'hC004_0000_0000_0000, 1'b1);						// -2.5
		pushDouble(64'h3F81_2345_6789_ABCD, 1'b1);
		idleCycles(1);
		waitDrain(40);
		idleCycles(4);
	endtask

	task automatic passSpecials();
		pushDouble(64'h7FF0_0000_0000_0000, 1'b1);	// +inf
		pushDouble(64'hFFF8_1234_5678_9ABC, 1'b1);	// nan with payload
		pushDouble(64'h0000_0000_0000_0000, 1'b1);
		pushDouble(64'h8000_0000_0000_0000, 1'b1);	// -0
		pushDouble(64'h000F_FFFF_FFFF_FFFF, 1'b1);	// denormal
		pushDouble(64'h8000_0123_4567_89AB, 1'b1);
		idleCycles(1);
		waitDrain(40);
		idleCycles(4);
	endtask

	task automatic saturateOutOfRange();
		pushDouble(makeDouble(1'b0, 11'h7FE, 52'hFFFFFFFFFFFFF), 1'b1);	// huge, +inf
		pushDouble(makeDouble(1'b1, 11'h480, 52'h0000000001234), 1'b1);	// -inf
		pushDouble(makeDouble(1'b0, 11'h001, 52'h0000000000001), 1'b1);	// tiny
		pushDouble(makeDouble(1'b1, 11'h37F, 52'hABCDEF0123456), 1'b1);	// tiny, still +0
		idleCycles(1);
		waitDrain(40);
		idleCycles(4);
	endtask

	task automatic holdWhileStoreLow();
		int i;
		setStore(1'b0);
		for (i = 0; i < 5; i++)
			pushDouble(randomDouble(1'b1), 1'b1);
		idleCycles(1);
		repeat (8)
		begin
			@(negedge clock);
			checkLevel("outVld", outVld, 1'b0);
		end
		setStore(1'b1);
		waitDrain(40);
		idleCycles(6);						// fifth single stays in the packer
		pushDouble(randomDouble(1'b1), 1'b1);
		idleCycles(1);
		waitDrain(40);
		idleCycles(4);
	endtask

	task automatic dropOnOverflow();
		int i;
		setStore(1'b0);
		for (i = 0; i < 8; i++)
			pushDouble(randomDouble(1'b1), 1'b1);
		idleCycles(3);
		@(negedge clock);
		checkLevel("overflow", overflow, 1'b0);	// exactly full, nothing lost yet
		pushDouble(randomDouble(1'b1), 1'b0);
		idleCycles(3);
		@(negedge clock);
		checkLevel("overflow", overflow, 1'b1);
		setStore(1'b1);
		waitDrain(60);
		idleCycles(6);
		@(negedge clock);
		checkLevel("overflow", overflow, 1'b1);	// sticky
	endtask

	task automatic randomTraffic();
		int                   i;
		int                   k;
		FpuCvtPkg::fpDouble_t d;
		lowRun = 0;
		for (i = 0; i < RandomItems; i++)
		begin
			d = randomDouble(($urandom % 2) == 1);
			@(posedge clock);
			inVld   <= 1'b1;
			inVal   <= d;
			storeEn <= pickStore();
			expectSingle(refConvert(d));
			for (k = 0; k < 2; k++)
			begin
				@(posedge clock);
				inVld   <= 1'b0;
				storeEn <= pickStore();
			end
		end
		setStore(1'b1);
		waitDrain(60);
		idleCycles(4);
		@(negedge clock);
		checkLevel("overflow", overflow, 1'b0);
	endtask

	// ********************
	// main sequence
	// ********************

	initial
	begin
		void'($urandom(32'hbe5a66d4));
		clock   = 1'b0;
		rst     = 1'b1;
		inVld   = 1'b0;
		inVal   = '0;
		storeEn = 1'b0;
		lowRun  = 0;
		repeat (16) @(posedge clock);
		rst <= 1'b0;

		convertInRange();
		passSpecials();
		saturateOutOfRange();
		holdWhileStoreLow();
		dropOnOverflow();

		applyReset();						// clears the sticky overflow
		@(negedge clock);
		checkLevel("overflow", overflow, 1'b0);
		randomTraffic();

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+tb
common/FpuCvtPkg.sv
source/FpuConvD2S.sv
source/FpuCvtStage.sv
source/FpuCvtFifo.sv
source/FpuPairPack.sv
source/FpuCvtUnit.sv
tb/FpuCvtUnitTb.sv
